// File: source/isaPkg.sv
// Processor shared definitions
package isaPkg;

	typedef logic [15:0] wordT;
	typedef logic [2:0] regIndexT;
	typedef logic [4:0] opcodeT;
	typedef logic [1:0] funcT;
	typedef logic [3:0] aluOpT;
	typedef logic [1:0] branchCondT;
	typedef logic [1:0] immSelT;

	// Opcodes, instr[15:11]
	localparam opcodeT opHalt     = 5'b00000;
	localparam opcodeT opNop      = 5'b00001;
	localparam opcodeT opSiic     = 5'b00010;
	localparam opcodeT opRti      = 5'b00011;
	localparam opcodeT opJ        = 5'b00100;
	localparam opcodeT opJr       = 5'b00101;
	localparam opcodeT opJal      = 5'b00110;
	localparam opcodeT opJalr     = 5'b00111;
	localparam opcodeT opAddi     = 5'b01000;
	localparam opcodeT opSubi     = 5'b01001;
	localparam opcodeT opXori     = 5'b01010;
	localparam opcodeT opAndi     = 5'b01011;
	localparam opcodeT opBeqz     = 5'b01100;
	localparam opcodeT opBnez     = 5'b01101;
	localparam opcodeT opBltz     = 5'b01110;
	localparam opcodeT opBgez     = 5'b01111;
	localparam opcodeT opSt       = 5'b10000;
	localparam opcodeT opLd       = 5'b10001;
	localparam opcodeT opSlbi     = 5'b10010;
	localparam opcodeT opStu      = 5'b10011;
	localparam opcodeT opRoli     = 5'b10100;
	localparam opcodeT opSlli     = 5'b10101;
	localparam opcodeT opRori     = 5'b10110;
	localparam opcodeT opSrli     = 5'b10111;
	localparam opcodeT opLbi      = 5'b11000;
	localparam opcodeT opBtr      = 5'b11001;
	localparam opcodeT opShiftReg = 5'b11010;
	localparam opcodeT opArithReg = 5'b11011;
	localparam opcodeT opSeq      = 5'b11100;
	localparam opcodeT opSlt      = 5'b11101;
	localparam opcodeT opSle      = 5'b11110;
	localparam opcodeT opSco      = 5'b11111;

	localparam aluOpT aluAdd   = 4'd0;
	localparam aluOpT aluSub   = 4'd1;
	localparam aluOpT aluXor   = 4'd2;
	localparam aluOpT aluAndn  = 4'd3;
	localparam aluOpT aluAnd   = 4'd4;
	localparam aluOpT aluRol   = 4'd5;
	localparam aluOpT aluSll   = 4'd6;
	localparam aluOpT aluRor   = 4'd7;
	localparam aluOpT aluSrl   = 4'd8;
	localparam aluOpT aluSeq   = 4'd9;
	localparam aluOpT aluSlt   = 4'd10;
	localparam aluOpT aluSle   = 4'd11;
	localparam aluOpT aluSco   = 4'd12;
	localparam aluOpT aluBtr   = 4'd13;
	localparam aluOpT aluPassB = 4'd14;

	// Matches the low two opcode bits of the branches
	localparam branchCondT condEqz = 2'd0;
	localparam branchCondT condNez = 2'd1;
	localparam branchCondT condLtz = 2'd2;
	localparam branchCondT condGez = 2'd3;

	localparam immSelT immSigned5   = 2'd0;
	localparam immSelT immUnsigned5 = 2'd1;
	localparam immSelT immSigned8   = 2'd2;
	localparam immSelT immDisp11    = 2'd3;

	typedef enum logic [1:0] {execute, busWait, halted} memStateT;

endpackage

// File: source/controlDecoder.sv
// Instruction control decoder
`timescale 1ns/1ps

module controlDecoder (
	input isaPkg::wordT instr,
	output logic regWrite,
	output logic aluSrc,
	output logic memWrite,
	output logic memRead,
	output logic memToReg,
	output logic branchCtl,
	output logic jumpCtl,
	output logic linkCtl,
	output logic stu,
	output logic lbi,
	output logic slbi,
	output logic stop,
	output isaPkg::aluOpT aluOp,
	output isaPkg::branchCondT branchCond,
	output isaPkg::immSelT immSelect,
	output isaPkg::regIndexT regTarget
);

	isaPkg::opcodeT opcode;
	isaPkg::funcT func;

	assign opcode = instr[15:11];
	assign func = instr[1:0];

	// Shared by the rotate/shift immediates and the register shift group
	function automatic isaPkg::aluOpT shiftOp(input logic [1:0] code);
		case (code)
			2'd0: shiftOp = isaPkg::aluRol;
			2'd1: shiftOp = isaPkg::aluSll;
			2'd2: shiftOp = isaPkg::aluRor;
			default: shiftOp = isaPkg::aluSrl;
		endcase
	endfunction

	function automatic isaPkg::aluOpT arithOp(input isaPkg::funcT code);
		case (code)
			2'd0: arithOp = isaPkg::aluAdd;
			2'd1: arithOp = isaPkg::aluSub;
			2'd2: arithOp = isaPkg::aluXor;
			default: arithOp = isaPkg::aluAndn;
		endcase
	endfunction

	always_comb begin
		regWrite = 1'b0;
		aluSrc = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		memToReg = 1'b0;
		branchCtl = 1'b0;
		jumpCtl = 1'b0;
		linkCtl = 1'b0;
		stu = 1'b0;
		lbi = 1'b0;
		slbi = 1'b0;
		stop = 1'b1;
		aluOp = isaPkg::aluAdd;
		branchCond = opcode[1:0];
		immSelect = isaPkg::immSigned5;
		regTarget = instr[7:5];
		case (opcode)
			isaPkg::opHalt, isaPkg::opSiic, isaPkg::opRti: begin
				stop = 1'b1;
			end
			isaPkg::opNop: begin
				stop = 1'b0;
			end
			isaPkg::opAddi, isaPkg::opSubi: begin
				stop = 1'b0;
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = opcode[0] ? isaPkg::aluSub : isaPkg::aluAdd;
			end
			isaPkg::opXori, isaPkg::opAndi: begin
				stop = 1'b0;
				regWrite = 1'b1;
				aluSrc = 1'b1;
				immSelect = isaPkg::immUnsigned5;
				aluOp = opcode[0] ? isaPkg::aluAnd : isaPkg::aluXor;
			end
			isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
				stop = 1'b0;
				regWrite = 1'b1;
				aluSrc = 1'b1;
				immSelect = isaPkg::immUnsigned5;
				aluOp = shiftOp(opcode[1:0]);
			end
			isaPkg::opArithReg, isaPkg::opShiftReg: begin
				stop = 1'b0;
				regWrite = 1'b1;
				regTarget = instr[4:2];
				aluOp = opcode[0] ? arithOp(func) : shiftOp(func);
			end
			isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco, isaPkg::opBtr: begin
				stop = 1'b0;
				regWrite = 1'b1;
				regTarget = instr[4:2];
				case (opcode)
					isaPkg::opSeq: aluOp = isaPkg::aluSeq;
					isaPkg::opSlt: aluOp = isaPkg::aluSlt;
					isaPkg::opSle: aluOp = isaPkg::aluSle;
					isaPkg::opSco: aluOp = isaPkg::aluSco;
					default: aluOp = isaPkg::aluBtr;
				endcase
			end
			isaPkg::opSt, isaPkg::opLd, isaPkg::opStu: begin
				stop = 1'b0;
				aluSrc = 1'b1;
				memToReg = 1'b1;
				memRead = (opcode == isaPkg::opLd);
				memWrite = (opcode != isaPkg::opLd);
				regWrite = (opcode != isaPkg::opSt);
				stu = (opcode == isaPkg::opStu);
				// stu writes the address back into rs
				if (opcode == isaPkg::opStu) begin
					regTarget = instr[10:8];
				end
			end
			isaPkg::opLbi, isaPkg::opSlbi: begin
				stop = 1'b0;
				regWrite = 1'b1;
				aluSrc = 1'b1;
				immSelect = isaPkg::immSigned8;
				regTarget = instr[10:8];
				lbi = (opcode == isaPkg::opLbi);
				slbi = (opcode == isaPkg::opSlbi);
				aluOp = slbi ? isaPkg::aluPassB : isaPkg::aluAdd;
			end
			isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
				stop = 1'b0;
				branchCtl = 1'b1;
				immSelect = isaPkg::immSigned8;
			end
			isaPkg::opJ, isaPkg::opJr, isaPkg::opJal, isaPkg::opJalr: begin
				stop = 1'b0;
				jumpCtl = 1'b1;
				// Odd opcodes are register based
				immSelect = opcode[0] ? isaPkg::immSigned8 : isaPkg::immDisp11;
				linkCtl = opcode[1];
				regWrite = opcode[1];
				regTarget = 3'd7;
			end
			default: begin
				stop = 1'b1;
			end
		endcase
	end

endmodule

// File: source/registerFile.sv
// Eight entry register file
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input isaPkg::regIndexT writeIndex,
	input isaPkg::regIndexT readIndexA,
	input isaPkg::regIndexT readIndexB,
	input isaPkg::wordT writeData,
	output isaPkg::wordT readDataA,
	output isaPkg::wordT readDataB
);

	isaPkg::wordT registers [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable) begin
			registers[writeIndex] <= writeData;
		end
	end

	// Asynchronous reads, no bypass
	assign readDataA = registers[readIndexA];
	assign readDataB = registers[readIndexB];

endmodule

// File: source/aluUnit.sv
// Processor ALU
`timescale 1ns/1ps

module aluUnit (
	input isaPkg::wordT operandA,
	input isaPkg::wordT operandB,
	input isaPkg::aluOpT aluOp,
	output isaPkg::wordT result
);

	logic [16:0] sum;
	logic [3:0] amount;
	logic [31:0] rotLeft;
	logic [31:0] rotRight;
	isaPkg::wordT reversed;

	assign amount = operandB[3:0];
	assign sum = {1'b0, operandA} + {1'b0, operandB};

	// Rotates through a doubled copy of the operand
	assign rotLeft = {operandA, operandA} << amount;
	assign rotRight = {operandA, operandA} >> amount;

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			reversed[i] = operandA[15 - i];
		end
	end

	always_comb begin
		case (aluOp)
			isaPkg::aluAdd: result = sum[15:0];
			isaPkg::aluSub: result = operandA - operandB;
			isaPkg::aluXor: result = operandA ^ operandB;
			isaPkg::aluAndn: result = operandA & ~operandB;
			isaPkg::aluAnd: result = operandA & operandB;
			isaPkg::aluRol: result = rotLeft[31:16];
			isaPkg::aluSll: result = operandA << amount;
			isaPkg::aluRor: result = rotRight[15:0];
			isaPkg::aluSrl: result = operandA >> amount;
			isaPkg::aluSeq: result = {15'd0, operandA == operandB};
			// Signed compares
			isaPkg::aluSlt: result = {15'd0, $signed(operandA) < $signed(operandB)};
			isaPkg::aluSle: result = {15'd0, $signed(operandA) <= $signed(operandB)};
			isaPkg::aluSco: result = {15'd0, sum[16]};
			isaPkg::aluBtr: result = reversed;
			isaPkg::aluPassB: result = operandB;
			default: result = sum[15:0];
		endcase
	end

endmodule

// File: source/programCounter.sv
// Program counter and branch resolution
`timescale 1ns/1ps

module programCounter #(
	parameter isaPkg::wordT resetVector = 16'h0000
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic branchCtl,
	input logic jumpCtl,
	input logic jumpRegister,
	input isaPkg::branchCondT branchCond,
	input isaPkg::wordT testValue,
	input isaPkg::wordT offset,
	input isaPkg::wordT baseRegister,
	output isaPkg::wordT pc,
	output isaPkg::wordT pcPlusTwo
);

	logic taken;
	isaPkg::wordT nextPc;

	assign pcPlusTwo = pc + 16'd2;

	always_comb begin
		case (branchCond)
			isaPkg::condEqz: taken = (testValue == '0);
			isaPkg::condNez: taken = (testValue != '0);
			isaPkg::condLtz: taken = testValue[15];
			isaPkg::condGez: taken = !testValue[15];
			default: taken = 1'b0;
		endcase
		if (jumpCtl && jumpRegister) begin
			nextPc = baseRegister + offset;
		end else if (jumpCtl || (branchCtl && taken)) begin
			nextPc = pcPlusTwo + offset;
		end else begin
			nextPc = pcPlusTwo;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetVector;
		end else if (advance) begin
			pc <= nextPc;
		end
	end

endmodule

// File: source/memoryInterface.sv
// Wishbone classic data master
`timescale 1ns/1ps

module memoryInterface (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic stop,
	input isaPkg::wordT address,
	input isaPkg::wordT storeData,
	input isaPkg::wordT datIn,
	input logic ack,
	output logic cyc,
	output logic stb,
	output logic we,
	output isaPkg::wordT adr,
	output isaPkg::wordT datOut,
	output isaPkg::wordT loadData,
	output logic stall,
	output logic retire,
	output logic halted
);

	isaPkg::memStateT state;
	logic memAccess;
	logic startAccess;

	assign memAccess = memRead || memWrite;
	assign startAccess = (state == isaPkg::execute) && memAccess;

	// Instruction is held while the bus cycle is open
	assign stall = startAccess || (state == isaPkg::busWait && !ack);
	assign retire = (state == isaPkg::execute && !stop) || (state == isaPkg::busWait);
	assign halted = (state == isaPkg::halted);
	assign loadData = datIn;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= isaPkg::execute;
			cyc <= 1'b0;
			stb <= 1'b0;
			we <= 1'b0;
		end else begin
			case (state)
				isaPkg::execute: begin
					if (stop) begin
						state <= isaPkg::halted;
					end else if (memAccess) begin
						state <= isaPkg::busWait;
						cyc <= 1'b1;
						stb <= 1'b1;
						we <= memWrite;
					end
				end
				isaPkg::busWait: begin
					if (ack) begin
						state <= isaPkg::execute;
						cyc <= 1'b0;
						stb <= 1'b0;
						we <= 1'b0;
					end
				end
				default: state <= isaPkg::halted;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (startAccess) begin
			adr <= address;
			datOut <= storeData;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		stb && !ack |=> $stable(adr) && $stable(we) && $stable(datOut))
		else $error("bus request changed before ack");

endmodule

// File: source/cpuCore.sv
// Processor core top level
`timescale 1ns/1ps

module cpuCore #(
	parameter isaPkg::wordT resetVector = 16'h0000
) (
	input logic clk,
	input logic reset,
	input isaPkg::wordT instr,
	input isaPkg::wordT datIn,
	input logic ack,
	output isaPkg::wordT pc,
	output isaPkg::wordT adr,
	output isaPkg::wordT datOut,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic halted
);

	logic regWrite, aluSrc, memWrite, memRead, memToReg;
	logic branchCtl, jumpCtl, linkCtl, stu, lbi, slbi, stop;
	logic stall, retire, commit, jumpRegister;
	isaPkg::aluOpT aluOp;
	isaPkg::branchCondT branchCond;
	isaPkg::immSelT immSelect;
	isaPkg::regIndexT regTarget;
	isaPkg::wordT immediate, aluA, aluB, aluResult;
	isaPkg::wordT readDataA, readDataB, writeData, loadData, pcPlusTwo;

	controlDecoder controlDecoder_inst (
		.instr(instr), .regWrite(regWrite), .aluSrc(aluSrc), .memWrite(memWrite),
		.memRead(memRead), .memToReg(memToReg), .branchCtl(branchCtl), .jumpCtl(jumpCtl),
		.linkCtl(linkCtl), .stu(stu), .lbi(lbi), .slbi(slbi), .stop(stop), .aluOp(aluOp),
		.branchCond(branchCond), .immSelect(immSelect), .regTarget(regTarget)
	);

	always_comb begin
		case (immSelect)
			isaPkg::immSigned5: immediate = {{11{instr[4]}}, instr[4:0]};
			isaPkg::immUnsigned5: immediate = {11'd0, instr[4:0]};
			isaPkg::immSigned8: immediate = {{8{instr[7]}}, instr[7:0]};
			isaPkg::immDisp11: immediate = {{5{instr[10]}}, instr[10:0]};
			default: immediate = '0;
		endcase
	end

	// lbi adds to zero, slbi passes the shifted and merged byte
	assign aluA = lbi ? '0 : readDataA;
	assign aluB = slbi ? {readDataA[7:0], instr[7:0]} : (aluSrc ? immediate : readDataB);

	// stu writes back the address, not the bus data
	assign writeData = linkCtl ? pcPlusTwo : ((memToReg && !stu) ? loadData : aluResult);
	assign commit = retire && !stall;
	assign jumpRegister = jumpCtl && (immSelect == isaPkg::immSigned8);

	registerFile registerFile_inst (
		.clk(clk), .reset(reset), .writeEnable(regWrite && commit), .writeIndex(regTarget),
		.readIndexA(instr[10:8]), .readIndexB(instr[7:5]), .writeData(writeData),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	aluUnit aluUnit_inst (.operandA(aluA), .operandB(aluB), .aluOp(aluOp), .result(aluResult));

	programCounter #(.resetVector(resetVector)) programCounter_inst (
		.clk(clk), .reset(reset), .advance(commit), .branchCtl(branchCtl), .jumpCtl(jumpCtl),
		.jumpRegister(jumpRegister), .branchCond(branchCond), .testValue(readDataA),
		.offset(immediate), .baseRegister(readDataA), .pc(pc), .pcPlusTwo(pcPlusTwo)
	);

	memoryInterface memoryInterface_inst (
		.clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite), .stop(stop),
		.address(aluResult), .storeData(readDataB), .datIn(datIn), .ack(ack), .cyc(cyc),
		.stb(stb), .we(we), .adr(adr), .datOut(datOut), .loadData(loadData), .stall(stall),
		.retire(retire), .halted(halted)
	);

	// Once stopped, the core stays frozen and off the bus
	assert property (@(posedge clk) disable iff (reset)
		(memoryInterface_inst.state == isaPkg::halted) |=> $stable(pc) && !cyc)
		else $error("core moved after halt");

endmodule

// File: testbench/cpuChecker.sv
// Instruction set reference checker
`timescale 1ns/1ps

module cpuChecker #(
	parameter isaPkg::wordT resetVector = 16'h0000
) (
	input logic clk,
	input logic reset,
	input isaPkg::wordT pc,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic ack,
	input isaPkg::wordT adr,
	input isaPkg::wordT datOut,
	input logic halted,
	input logic endOfRun,
	input isaPkg::wordT rom [64],
	input isaPkg::wordT memImage [256],
	output int errorCount,
	output int storeCount
);

	isaPkg::wordT expAddr [$];
	isaPkg::wordT expData [$];
	isaPkg::wordT expectedHaltPc;
	isaPkg::wordT wantAddr;
	isaPkg::wordT wantData;
	int errors = 0;
	int stores = 0;
	logic refReady = 1'b0;
	logic haltSeen = 1'b0;
	logic busAfterHalt = 1'b0;
	logic finalDone = 1'b0;

	assign errorCount = errors;
	assign storeCount = stores;

	function automatic isaPkg::wordT rotateLeft(input isaPkg::wordT value, input logic [3:0] n);
		return (value << n) | (value >> (5'd16 - {1'b0, n}));
	endfunction

	function automatic isaPkg::wordT rotateRight(input isaPkg::wordT value, input logic [3:0] n);
		return (value >> n) | (value << (5'd16 - {1'b0, n}));
	endfunction

	// Bit 0 is shifted in first and ends up on top
	function automatic isaPkg::wordT reverseBits(input isaPkg::wordT value);
		isaPkg::wordT r;
		r = '0;
		for (int i = 0; i < 16; i++) begin
			r = {r[14:0], value[i]};
		end
		return r;
	endfunction

	function automatic isaPkg::wordT shiftBy(input logic [1:0] kind, input isaPkg::wordT a,
		input isaPkg::wordT b);
		case (kind)
			2'd0: return rotateLeft(a, b[3:0]);
			2'd1: return a << b[3:0];
			2'd2: return rotateRight(a, b[3:0]);
			default: return a >> b[3:0];
		endcase
	endfunction

	// Steps the program from resetVector and records every store
	function automatic void computeExpected();
		isaPkg::wordT regs [8];
		isaPkg::wordT mem [256];
		isaPkg::wordT curPc, nextPc, ins, a, b, sImm5, uImm5, sImm8, disp, addr;
		isaPkg::opcodeT op;
		logic done;
		int steps;
		for (int i = 0; i < 8; i++) regs[i] = '0;
		for (int i = 0; i < 256; i++) mem[i] = memImage[i];
		curPc = resetVector;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			ins = rom[curPc[6:1]];
			op = ins[15:11];
			a = regs[ins[10:8]];
			b = regs[ins[7:5]];
			sImm5 = {{11{ins[4]}}, ins[4:0]};
			uImm5 = {11'd0, ins[4:0]};
			sImm8 = {{8{ins[7]}}, ins[7:0]};
			disp = {{5{ins[10]}}, ins[10:0]};
			addr = a + sImm5;
			nextPc = curPc + 16'd2;
			case (op)
				isaPkg::opNop: ;
				isaPkg::opAddi: regs[ins[7:5]] = a + sImm5;
				isaPkg::opSubi: regs[ins[7:5]] = a - sImm5;
				isaPkg::opXori: regs[ins[7:5]] = a ^ uImm5;
				isaPkg::opAndi: regs[ins[7:5]] = a & uImm5;
				isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli:
					regs[ins[7:5]] = shiftBy(op[1:0], a, uImm5);
				isaPkg::opShiftReg: regs[ins[4:2]] = shiftBy(ins[1:0], a, b);
				isaPkg::opArithReg: begin
					case (ins[1:0])
						2'd0: regs[ins[4:2]] = a + b;
						2'd1: regs[ins[4:2]] = a - b;
						2'd2: regs[ins[4:2]] = a ^ b;
						default: regs[ins[4:2]] = a & ~b;
					endcase
				end
				isaPkg::opSeq: regs[ins[4:2]] = {15'd0, a == b};
				isaPkg::opSlt: regs[ins[4:2]] = {15'd0, $signed(a) < $signed(b)};
				isaPkg::opSle: regs[ins[4:2]] = {15'd0, $signed(a) <= $signed(b)};
				// A carry leaves the wrapped sum below a
				isaPkg::opSco: regs[ins[4:2]] = {15'd0, (a + b) < a};
				isaPkg::opBtr: regs[ins[4:2]] = reverseBits(a);
				isaPkg::opLbi: regs[ins[10:8]] = sImm8;
				isaPkg::opSlbi: regs[ins[10:8]] = (a << 8) | {8'd0, ins[7:0]};
				isaPkg::opLd: regs[ins[7:5]] = mem[addr[8:1]];
				isaPkg::opSt, isaPkg::opStu: begin
					expAddr.push_back(addr);
					expData.push_back(b);
					mem[addr[8:1]] = b;
					if (op == isaPkg::opStu) regs[ins[10:8]] = addr;
				end
				isaPkg::opBeqz: if (a == 16'd0) nextPc = curPc + 16'd2 + sImm8;
				isaPkg::opBnez: if (a != 16'd0) nextPc = curPc + 16'd2 + sImm8;
				isaPkg::opBltz: if (a[15]) nextPc = curPc + 16'd2 + sImm8;
				isaPkg::opBgez: if (!a[15]) nextPc = curPc + 16'd2 + sImm8;
				isaPkg::opJ: nextPc = curPc + 16'd2 + disp;
				isaPkg::opJal: begin
					regs[7] = curPc + 16'd2;
					nextPc = curPc + 16'd2 + disp;
				end
				isaPkg::opJr: nextPc = a + sImm8;
				isaPkg::opJalr: begin
					regs[7] = curPc + 16'd2;
					nextPc = a + sImm8;
				end
				// halt, siic, rti and anything undefined
				default: done = 1'b1;
			endcase
			if (!done) curPc = nextPc;
			steps++;
		end
		expectedHaltPc = curPc;
	endfunction

	task automatic compareStore();
		stores++;
		if (expAddr.size() == 0) begin
			errors++;
			$display("Extra store to address %h that the reference does not predict", adr);
		end else begin
			wantAddr = expAddr.pop_front();
			wantData = expData.pop_front();
			if (adr !== wantAddr) begin
				errors++;
				$display("FAILED adr: got %h expected %h", adr, wantAddr);
			end
			if (datOut !== wantData) begin
				errors++;
				$display("FAILED datOut: got %h expected %h", datOut, wantData);
			end
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (!refReady) begin
				computeExpected();
				refReady = 1'b1;
			end
			if (cyc && stb && we && ack) compareStore();
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				if (pc !== expectedHaltPc) begin
					errors++;
					$display("FAILED pc: got %h expected %h", pc, expectedHaltPc);
				end
			end else if (haltSeen && cyc && !busAfterHalt) begin
				busAfterHalt = 1'b1;
				errors++;
				$display("A bus cycle started after the core halted");
			end
			if (endOfRun && !finalDone) begin
				finalDone = 1'b1;
				if (expAddr.size() != 0) begin
					errors++;
					$display("%0d expected stores never appeared on the bus", expAddr.size());
				end
			end
		end
	end

endmodule

// File: testbench/cpuTb.sv
// Processor core testbench
`timescale 1ns/1ps

module cpuTb;

	localparam isaPkg::wordT startAddress = 16'h0000;
	localparam int romDepth = 64;
	// 1 execute, up to 3 waits and 1 margin per instruction
	localparam int timeoutLimit = romDepth * 5 + 200;

	logic clk = 1'b0;
	logic reset;
	logic ack;
	logic cyc;
	logic stb;
	logic we;
	logic halted;
	logic endOfRun;
	isaPkg::wordT instr;
	isaPkg::wordT pc;
	isaPkg::wordT adr;
	isaPkg::wordT datIn;
	isaPkg::wordT datOut;
	isaPkg::wordT instrRom [romDepth];
	isaPkg::wordT memImage [256];
	isaPkg::wordT dataMem [256];
	int errorCount;
	int storeCount;
	int cycleCount = 0;
	int waitLeft = 0;
	logic busy = 1'b0;
	int romFill = 0;

	always #2 clk = ~clk;

	assign instr = instrRom[pc[6:1]];

	cpuCore #(.resetVector(startAddress)) cpuCore_inst (
		.clk(clk), .reset(reset), .instr(instr), .datIn(datIn), .ack(ack), .pc(pc),
		.adr(adr), .datOut(datOut), .cyc(cyc), .stb(stb), .we(we), .halted(halted)
	);

	cpuChecker #(.resetVector(startAddress)) cpuChecker_inst (
		.clk(clk), .reset(reset), .pc(pc), .cyc(cyc), .stb(stb), .we(we), .ack(ack),
		.adr(adr), .datOut(datOut), .halted(halted), .endOfRun(endOfRun),
		.rom(instrRom), .memImage(memImage), .errorCount(errorCount), .storeCount(storeCount)
	);

	function automatic isaPkg::wordT immInstr(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm5);
		return {op, rs, rd, imm5};
	endfunction

	function automatic isaPkg::wordT regInstr(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic isaPkg::wordT byteInstr(input isaPkg::opcodeT op, input logic [2:0] rs,
		input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	function automatic isaPkg::wordT jumpInstr(input isaPkg::opcodeT op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic emit(input isaPkg::wordT word);
		instrRom[romFill] = word;
		romFill++;
	endtask

	// Result in r3, then pushed out through r6 with stu
	task automatic opAndStore(input isaPkg::wordT word);
		emit(word);
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd3, 5'd2));
	endtask

	task automatic buildProgram();
		isaPkg::opcodeT immOps [8];
		immOps = '{isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndi,
			isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli};
		emit(byteInstr(isaPkg::opLbi, 3'd1, 8'($urandom)));
		emit(byteInstr(isaPkg::opSlbi, 3'd1, 8'($urandom)));
		// r2 comes from the top word of the random memory image
		emit(immInstr(isaPkg::opLd, 3'd0, 3'd2, 5'b11110));
		for (int i = 0; i < 8; i++) begin
			opAndStore(immInstr(immOps[i], 3'd1, 3'd3, 5'($urandom)));
		end
		for (int f = 0; f < 4; f++) begin
			opAndStore(regInstr(isaPkg::opArithReg, 3'd1, 3'd2, 3'd3, 2'(f)));
		end
		for (int f = 0; f < 4; f++) begin
			opAndStore(regInstr(isaPkg::opShiftReg, 3'd1, 3'd2, 3'd3, 2'(f)));
		end
		opAndStore(regInstr(isaPkg::opSeq, 3'd1, 3'd2, 3'd3, 2'd0));
		opAndStore(regInstr(isaPkg::opSlt, 3'd1, 3'd2, 3'd3, 2'd0));
		opAndStore(regInstr(isaPkg::opSle, 3'd1, 3'd2, 3'd3, 2'd0));
		opAndStore(regInstr(isaPkg::opSco, 3'd1, 3'd2, 3'd3, 2'd0));
		opAndStore(regInstr(isaPkg::opBtr, 3'd1, 3'd2, 3'd3, 2'd0));
		// Load back the last stored word
		emit(immInstr(isaPkg::opLd, 3'd6, 3'd4, 5'd0));
		// st keeps r6 and the next stu reuses its address
		emit(immInstr(isaPkg::opSt, 3'd6, 3'd4, 5'd2));
		emit(byteInstr(isaPkg::opBeqz, 3'd0, 8'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd1, 5'd2));
		emit(byteInstr(isaPkg::opBnez, 3'd0, 8'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd2, 5'd2));
		emit(byteInstr(isaPkg::opBltz, 3'd1, 8'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd1, 5'd2));
		emit(byteInstr(isaPkg::opBgez, 3'd1, 8'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd2, 5'd2));
		emit(jumpInstr(isaPkg::opJ, 11'd2));
		// Final halt at 0x70, reached through jr
		emit(16'h0000);
		emit(jumpInstr(isaPkg::opJal, 11'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd1, 5'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd7, 5'd2));
		emit(byteInstr(isaPkg::opJalr, 3'd0, 8'd124));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd2, 5'd2));
		emit(immInstr(isaPkg::opStu, 3'd6, 3'd7, 5'd2));
		emit(byteInstr(isaPkg::opJr, 3'd0, 8'd112));
	endtask

	// Wishbone slave with 0 to 3 wait cycles
	always @(negedge clk) begin
		ack = 1'b0;
		if (!reset && cyc && stb) begin
			if (!busy) begin
				busy = 1'b1;
				waitLeft = int'($urandom % 4);
			end
			if (waitLeft == 0) begin
				ack = 1'b1;
				busy = 1'b0;
				datIn = dataMem[adr[8:1]];
				if (we) begin
					dataMem[adr[8:1]] = datOut;
				end
			end else begin
				waitLeft--;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		void'($urandom(87));
		reset = 1'b1;
		ack = 1'b0;
		datIn = '0;
		endOfRun = 1'b0;
		buildProgram();
		for (int i = 0; i < 256; i++) begin
			memImage[i] = 16'($urandom);
			dataMem[i] = memImage[i];
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		while (!halted) @(negedge clk);
		// Bus must stay quiet after halt
		repeat (20) @(negedge clk);
		endOfRun = 1'b1;
		repeat (2) @(negedge clk);
		$display("Stores checked: %0d, errors: %0d", storeCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: vlog.f
source/isaPkg.sv
source/controlDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/programCounter.sv
source/memoryInterface.sv
source/cpuCore.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module cpuTb -o cpuSim > build.log 2>&1 &&
./obj_dir/cpuSim > sim.log 2>&1 ||
{ cat build.log; echo "Build or simulation run failed"; exit 1; }
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
else
	exit 0
fi
